// ==== dds_pkg.sv ====
package dds_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths that carry a meaning
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [31:0]        phase_t;      // accumulator and tuning words
   typedef logic signed [11:0] sample_t;     // full scale +/-2047
   typedef logic [7:0]         scan_code_t;  // keyboard event code
   typedef logic [4:0]         lfsr_t;
   typedef logic [7:0]         held_keys_t;  // bit 0 is digit key 1

   typedef enum logic [1:0] {
      WAVE_SINE,
      WAVE_COSINE,
      WAVE_SQUARE,
      WAVE_SAW
   } wave_sel_t;

   typedef enum logic [1:0] {
      MOD_ASK,
      MOD_BPSK,
      MOD_FSK
   } mod_sel_t;

   ////////////////////////////////////////////////////////////////////////////
   // digit key events, make codes are ps/2 set 2
   ////////////////////////////////////////////////////////////////////////////

   localparam scan_code_t SC_MAKE_1  = 8'h16;
   localparam scan_code_t SC_MAKE_2  = 8'h1E;
   localparam scan_code_t SC_MAKE_3  = 8'h26;
   localparam scan_code_t SC_MAKE_4  = 8'h25;
   localparam scan_code_t SC_MAKE_5  = 8'h2E;
   localparam scan_code_t SC_MAKE_6  = 8'h36;
   localparam scan_code_t SC_MAKE_7  = 8'h3D;
   localparam scan_code_t SC_MAKE_8  = 8'h3E;

   // break events carry the make code with bit 7 set
   localparam scan_code_t SC_BREAK_1 = 8'h96;
   localparam scan_code_t SC_BREAK_2 = 8'h9E;
   localparam scan_code_t SC_BREAK_3 = 8'hA6;
   localparam scan_code_t SC_BREAK_4 = 8'hA5;
   localparam scan_code_t SC_BREAK_5 = 8'hAE;
   localparam scan_code_t SC_BREAK_6 = 8'hB6;
   localparam scan_code_t SC_BREAK_7 = 8'hBD;
   localparam scan_code_t SC_BREAK_8 = 8'hBE;

   ////////////////////////////////////////////////////////////////////////////
   // one sine period, round(2047 * sin(2*pi*i/64))
   ////////////////////////////////////////////////////////////////////////////

   localparam int SINE_ADDR_W = 6;

   localparam sample_t SINE_TABLE [64] = '{
          0,   201,   399,   594,   783,   965,  1137,  1299,
       1447,  1582,  1702,  1805,  1891,  1959,  2008,  2037,
       2047,  2037,  2008,  1959,  1891,  1805,  1702,  1582,
       1447,  1299,  1137,   965,   783,   594,   399,   201,
          0,  -201,  -399,  -594,  -783,  -965, -1137, -1299,
      -1447, -1582, -1702, -1805, -1891, -1959, -2008, -2037,
      -2047, -2037, -2008, -1959, -1891, -1805, -1702, -1582,
      -1447, -1299, -1137,  -965,  -783,  -594,  -399,  -201
   };

endpackage

// ==== lab_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module lab_control #(
   parameter int unsigned SAMPLE_PERIOD = 70000
) (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  logic                key_event_ready,
   input  dds_pkg::scan_code_t key_event,
   output dds_pkg::wave_sel_t  wave_sel,
   output dds_pkg::mod_sel_t   mod_sel,
   output dds_pkg::held_keys_t held_keys,
   output logic                sample_strobe
);

   localparam int NUM_KEYS = $bits(dds_pkg::held_keys_t);
   localparam int CNT_W    = (SAMPLE_PERIOD > 1) ? $clog2(SAMPLE_PERIOD) : 1;

   localparam dds_pkg::scan_code_t MAKE_CODES [NUM_KEYS] = '{
      dds_pkg::SC_MAKE_1, dds_pkg::SC_MAKE_2, dds_pkg::SC_MAKE_3, dds_pkg::SC_MAKE_4,
      dds_pkg::SC_MAKE_5, dds_pkg::SC_MAKE_6, dds_pkg::SC_MAKE_7, dds_pkg::SC_MAKE_8
   };
   localparam dds_pkg::scan_code_t BREAK_CODES [NUM_KEYS] = '{
      dds_pkg::SC_BREAK_1, dds_pkg::SC_BREAK_2, dds_pkg::SC_BREAK_3, dds_pkg::SC_BREAK_4,
      dds_pkg::SC_BREAK_5, dds_pkg::SC_BREAK_6, dds_pkg::SC_BREAK_7, dds_pkg::SC_BREAK_8
   };

   dds_pkg::held_keys_t make_hit;   // one-hot per digit, qualified by ready
   dds_pkg::held_keys_t break_hit;
   logic [CNT_W-1:0]    sample_cnt;

   ////////////////////////////////////////////////////////////////////////////
   // key event decode
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int i = 0; i < NUM_KEYS; i++)
      begin
         make_hit[i]  = key_event_ready && (key_event == MAKE_CODES[i]);
         break_hit[i] = key_event_ready && (key_event == BREAK_CODES[i]);
      end
   end

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         held_keys <= '0;
         wave_sel  <= dds_pkg::WAVE_SINE;
         mod_sel   <= dds_pkg::MOD_ASK;
      end
      else
      begin
         held_keys <= (held_keys | make_hit) & ~break_hit;

         // digits 1..4 pick the waveform
         if (make_hit[0])      wave_sel <= dds_pkg::WAVE_SINE;
         else if (make_hit[1]) wave_sel <= dds_pkg::WAVE_COSINE;
         else if (make_hit[2]) wave_sel <= dds_pkg::WAVE_SQUARE;
         else if (make_hit[3]) wave_sel <= dds_pkg::WAVE_SAW;

         // digits 5..7 pick the keying, 8 is only tracked
         if (make_hit[4])      mod_sel <= dds_pkg::MOD_ASK;
         else if (make_hit[5]) mod_sel <= dds_pkg::MOD_BPSK;
         else if (make_hit[6]) mod_sel <= dds_pkg::MOD_FSK;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // scope sample pacing
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         sample_cnt <= '0;
      else if (sample_strobe)
         sample_cnt <= '0;
      else
         sample_cnt <= sample_cnt + 1'b1;
   end

   assign sample_strobe = (sample_cnt == CNT_W'(SAMPLE_PERIOD - 1));  // last count

   a_strobe_single : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      sample_strobe |=> !sample_strobe);

endmodule

`default_nettype wire

// ==== lfsr_bit_source.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_bit_source #(
   parameter int unsigned BIT_PERIOD = 25000000
) (
   input  logic CLK_25MHZ,
   input  logic reset_from_key,
   output logic data_bit
);

   localparam int CNT_W = (BIT_PERIOD > 1) ? $clog2(BIT_PERIOD) : 1;

   logic [CNT_W-1:0] bit_cnt;
   logic             bit_step;   // last cycle of the bit period
   dds_pkg::lfsr_t   lfsr;

   assign bit_step = (bit_cnt == CNT_W'(BIT_PERIOD - 1));

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         bit_cnt <= '0;
      else if (bit_step)
         bit_cnt <= '0;
      else
         bit_cnt <= bit_cnt + 1'b1;
   end

   // x^5 + x^3 + 1, 31 states before it repeats
   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         lfsr <= 5'b00001;
      else if (bit_step)
         lfsr <= {lfsr[3:0], lfsr[4] ^ lfsr[2]};
   end

   assign data_bit = lfsr[0];

   // the all zero state would lock the sequence
   a_lfsr_alive : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      lfsr != '0);

endmodule

`default_nettype wire

// ==== dds_waveform.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_waveform #(
   parameter dds_pkg::phase_t CARRIER_INC = 32'd258,
   parameter dds_pkg::phase_t FSK_INC     = 32'd516
) (
   input  logic               CLK_25MHZ,
   input  logic               reset_from_key,
   input  dds_pkg::wave_sel_t wave_sel,
   input  dds_pkg::mod_sel_t  mod_sel,
   input  logic               data_bit,
   output dds_pkg::sample_t   carrier,
   output dds_pkg::sample_t   wave_out
);

   localparam int PHASE_W  = $bits(dds_pkg::phase_t);
   localparam int SAMPLE_W = $bits(dds_pkg::sample_t);
   localparam int ADDR_W   = dds_pkg::SINE_ADDR_W;

   localparam dds_pkg::sample_t FULL_SCALE = 2047;

   dds_pkg::phase_t  phase;
   dds_pkg::phase_t  tuning_word;
   logic [ADDR_W-1:0] sin_addr;
   logic [ADDR_W-1:0] cos_addr;
   dds_pkg::sample_t  sin_value;
   dds_pkg::sample_t  cos_value;
   dds_pkg::sample_t  square_value;
   dds_pkg::sample_t  saw_value;

   // fsk swaps the tuning word while the data bit is high
   assign tuning_word = (mod_sel == dds_pkg::MOD_FSK && data_bit) ? FSK_INC : CARRIER_INC;

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + tuning_word;
   end

   ////////////////////////////////////////////////////////////////////////////
   // waveform decodes from the current phase
   ////////////////////////////////////////////////////////////////////////////

   assign sin_addr  = phase[PHASE_W-1 -: ADDR_W];
   assign cos_addr  = sin_addr + ADDR_W'(16);   // quarter period ahead, wraps
   assign sin_value = dds_pkg::SINE_TABLE[sin_addr];
   assign cos_value = dds_pkg::SINE_TABLE[cos_addr];

   assign square_value = phase[PHASE_W-1] ? -FULL_SCALE : FULL_SCALE;

   // offset binary to two's complement
   assign saw_value = {~phase[PHASE_W-1], phase[PHASE_W-2 -: SAMPLE_W-1]};

   always_comb
   begin
      case (wave_sel)
         dds_pkg::WAVE_SINE:   wave_out = sin_value;
         dds_pkg::WAVE_COSINE: wave_out = cos_value;
         dds_pkg::WAVE_SQUARE: wave_out = square_value;
         default:              wave_out = saw_value;
      endcase
   end

   assign carrier = sin_value;

endmodule

`default_nettype wire

// ==== shift_keyer.sv ====
`timescale 1ns/1ps
`default_nettype none

module shift_keyer (
   input  logic              CLK_25MHZ,
   input  logic              reset_from_key,
   input  dds_pkg::mod_sel_t mod_sel,
   input  logic              data_bit,
   input  dds_pkg::sample_t  carrier,
   input  dds_pkg::sample_t  wave_out,
   input  logic              sample_strobe,
   output dds_pkg::sample_t  sig_sample,
   output dds_pkg::sample_t  mod_sample,
   output logic              sample_valid
);

   dds_pkg::sample_t mod_value;

   always_comb
   begin
      case (mod_sel)
         dds_pkg::MOD_ASK:  mod_value = data_bit ? carrier : '0;       // on/off
         dds_pkg::MOD_BPSK: mod_value = data_bit ? carrier : -carrier; // 180 deg flip
         default:           mod_value = carrier;  // fsk already shifted the phase step
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // scope trace registers
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLK_25MHZ)
   begin
      if (reset_from_key)
      begin
         sig_sample   <= '0;
         mod_sample   <= '0;
         sample_valid <= 1'b0;
      end
      else
      begin
         sample_valid <= sample_strobe;
         if (sample_strobe)
         begin
            sig_sample <= wave_out;
            mod_sample <= mod_value;
         end
      end
   end

   // a valid pulse never stretches into a second cycle
   a_valid_single : assert property (@(posedge CLK_25MHZ) disable iff (reset_from_key)
      sample_valid |=> !sample_valid);

endmodule

`default_nettype wire

// ==== dds_lab_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dds_lab_top #(
   parameter dds_pkg::phase_t CARRIER_INC   = 32'd258,
   parameter dds_pkg::phase_t FSK_INC       = 32'd516,
   parameter int unsigned     BIT_PERIOD    = 25000000,   // 1 hz data rate
   parameter int unsigned     SAMPLE_PERIOD = 70000
) (
   input  logic                CLK_25MHZ,
   input  logic                reset_from_key,
   input  logic                key_event_ready,
   input  dds_pkg::scan_code_t key_event,
   output dds_pkg::held_keys_t held_keys,
   output logic                data_bit,
   output dds_pkg::sample_t    sig_sample,
   output dds_pkg::sample_t    mod_sample,
   output logic                sample_valid
);

   dds_pkg::wave_sel_t wave_sel;
   dds_pkg::mod_sel_t  mod_sel;
   logic               sample_strobe;
   dds_pkg::sample_t   carrier;
   dds_pkg::sample_t   wave_out;

   lab_control #(
      .SAMPLE_PERIOD (SAMPLE_PERIOD)
   ) u_lab_control (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_ready (key_event_ready),
      .key_event       (key_event),
      .wave_sel        (wave_sel),
      .mod_sel         (mod_sel),
      .held_keys       (held_keys),
      .sample_strobe   (sample_strobe)
   );

   lfsr_bit_source #(
      .BIT_PERIOD (BIT_PERIOD)
   ) u_lfsr_bit_source (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .data_bit       (data_bit)
   );

   dds_waveform #(
      .CARRIER_INC (CARRIER_INC),
      .FSK_INC     (FSK_INC)
   ) u_dds_waveform (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .wave_sel       (wave_sel),
      .mod_sel        (mod_sel),
      .data_bit       (data_bit),
      .carrier        (carrier),
      .wave_out       (wave_out)
   );

   shift_keyer u_shift_keyer (
      .CLK_25MHZ      (CLK_25MHZ),
      .reset_from_key (reset_from_key),
      .mod_sel        (mod_sel),
      .data_bit       (data_bit),
      .carrier        (carrier),
      .wave_out       (wave_out),
      .sample_strobe  (sample_strobe),
      .sig_sample     (sig_sample),
      .mod_sample     (mod_sample),
      .sample_valid   (sample_valid)
   );

endmodule

`default_nettype wire

// ==== tb_dds_lab.sv ====
`timescale 1ns/1ps

module tb_dds_lab;

   localparam int unsigned     BIT_PERIOD     = 16;
   localparam int unsigned     SAMPLE_PERIOD  = 7;
   localparam dds_pkg::phase_t CARRIER_INC    = 32'h0400_0000;
   localparam dds_pkg::phase_t FSK_INC        = 32'h0A00_0000;
   localparam int              RESET_CYCLES   = 8;
   localparam int              RUN_CYCLES     = 3000;
   localparam int              TIMEOUT_CYCLES = RUN_CYCLES + RUN_CYCLES / 6;  // 3500

   localparam dds_pkg::scan_code_t MAKE_CODES [8] = '{
      dds_pkg::SC_MAKE_1, dds_pkg::SC_MAKE_2, dds_pkg::SC_MAKE_3, dds_pkg::SC_MAKE_4,
      dds_pkg::SC_MAKE_5, dds_pkg::SC_MAKE_6, dds_pkg::SC_MAKE_7, dds_pkg::SC_MAKE_8
   };
   localparam dds_pkg::scan_code_t BREAK_CODES [8] = '{
      dds_pkg::SC_BREAK_1, dds_pkg::SC_BREAK_2, dds_pkg::SC_BREAK_3, dds_pkg::SC_BREAK_4,
      dds_pkg::SC_BREAK_5, dds_pkg::SC_BREAK_6, dds_pkg::SC_BREAK_7, dds_pkg::SC_BREAK_8
   };

   logic                CLK_25MHZ;
   logic                reset_from_key;
   logic                key_event_ready;
   dds_pkg::scan_code_t key_event;
   dds_pkg::held_keys_t held_keys;
   logic                data_bit;
   dds_pkg::sample_t    sig_sample;
   dds_pkg::sample_t    mod_sample;
   logic                sample_valid;

   // cycle model state
   dds_pkg::wave_sel_t  m_wave;
   dds_pkg::mod_sel_t   m_mod_sel;
   dds_pkg::wave_sel_t  m_sampled_wave;   // wave_sel in the last strobe cycle
   dds_pkg::held_keys_t m_held;
   dds_pkg::lfsr_t      m_lfsr;
   dds_pkg::phase_t     m_phase;
   int                  m_sample_cnt;
   int                  m_bit_cnt;
   dds_pkg::sample_t    m_sig;
   dds_pkg::sample_t    m_mod;
   logic                m_valid;

   logic                drv_ready;        // what the dut samples at the next edge
   dds_pkg::scan_code_t drv_code;
   logic [3:0]          waves_seen;
   int                  since_valid;
   int                  valid_count;
   int                  cycle_count = 0;

   dds_lab_top #(
      .CARRIER_INC   (CARRIER_INC),
      .FSK_INC       (FSK_INC),
      .BIT_PERIOD    (BIT_PERIOD),
      .SAMPLE_PERIOD (SAMPLE_PERIOD)
   ) u_dut (
      .CLK_25MHZ       (CLK_25MHZ),
      .reset_from_key  (reset_from_key),
      .key_event_ready (key_event_ready),
      .key_event       (key_event),
      .held_keys       (held_keys),
      .data_bit        (data_bit),
      .sig_sample      (sig_sample),
      .mod_sample      (mod_sample),
      .sample_valid    (sample_valid)
   );

   initial
   begin
      CLK_25MHZ = 1'b0;
      forever #20 CLK_25MHZ = ~CLK_25MHZ;
   end

   ////////////////////////////////////////////////////////////////////////////
   // failure reporting and compare tasks
   ////////////////////////////////////////////////////////////////////////////

   task automatic stop_with_failure();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_sample(string what, dds_pkg::sample_t actual,
                               dds_pkg::sample_t expected);
      if (actual !== expected)
      begin
         $display("mismatch at %0t ns: %s is %0d, model expects %0d",
                  $time, what, actual, expected);
         stop_with_failure();
      end
   endtask

   task automatic check_keys(dds_pkg::held_keys_t actual, dds_pkg::held_keys_t expected);
      if (actual !== expected)
      begin
         $display("mismatch at %0t ns: held_keys is %b, model expects %b",
                  $time, actual, expected);
         stop_with_failure();
      end
   endtask

   task automatic check_bit(string what, logic actual, logic expected);
      if (actual !== expected)
      begin
         $display("mismatch at %0t ns: %s is %b, model expects %b",
                  $time, what, actual, expected);
         stop_with_failure();
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////////////////////

   // 1..8 for a digit key event of the given kind, 0 otherwise
   function automatic int digit_of(dds_pkg::scan_code_t code, logic is_break);
      int digit;
      digit = 0;
      for (int i = 0; i < 8; i++)
      begin
         if (code == (is_break ? BREAK_CODES[i] : MAKE_CODES[i]))
            digit = i + 1;
      end
      return digit;
   endfunction

   function automatic dds_pkg::sample_t expected_wave(dds_pkg::wave_sel_t sel,
                                                      dds_pkg::phase_t ph);
      int idx;
      idx = int'(ph >> (32 - dds_pkg::SINE_ADDR_W));  // table index from top bits
      case (sel)
         dds_pkg::WAVE_SINE:   return dds_pkg::SINE_TABLE[idx];
         dds_pkg::WAVE_COSINE: return dds_pkg::SINE_TABLE[(idx + 16) % 64];
         dds_pkg::WAVE_SQUARE: return ph[31] ? dds_pkg::sample_t'(-2047) : 12'sd2047;
         default:              return dds_pkg::sample_t'(int'(ph >> 20) - 2048);
      endcase
   endfunction

   function automatic dds_pkg::sample_t expected_keyed(dds_pkg::mod_sel_t sel, logic bit_in,
                                                       dds_pkg::sample_t c);
      case (sel)
         dds_pkg::MOD_ASK:  return bit_in ? c : dds_pkg::sample_t'(0);
         dds_pkg::MOD_BPSK: return bit_in ? c : dds_pkg::sample_t'(-c);
         default:           return c;
      endcase
   endfunction

   task automatic reset_model();
      m_wave         = dds_pkg::WAVE_SINE;
      m_mod_sel      = dds_pkg::MOD_ASK;
      m_sampled_wave = dds_pkg::WAVE_SINE;
      m_held         = '0;
      m_lfsr         = 5'b00001;
      m_phase        = '0;
      m_sample_cnt   = 0;
      m_bit_cnt      = 0;
      m_sig          = '0;
      m_mod          = '0;
      m_valid        = 1'b0;
   endtask

   // one rising edge, using the values present before it
   task automatic step_model();
      logic            strobe;
      logic            bit_step;
      int              digit;
      dds_pkg::phase_t tuning;
      strobe   = (m_sample_cnt == SAMPLE_PERIOD - 1);
      bit_step = (m_bit_cnt == BIT_PERIOD - 1);
      tuning   = (m_mod_sel == dds_pkg::MOD_FSK && m_lfsr[0]) ? FSK_INC : CARRIER_INC;
      if (strobe)
      begin
         m_sig          = expected_wave(m_wave, m_phase);
         m_mod          = expected_keyed(m_mod_sel, m_lfsr[0],
                                         expected_wave(dds_pkg::WAVE_SINE, m_phase));
         m_sampled_wave = m_wave;
      end
      m_valid = strobe;
      if (drv_ready)
      begin
         digit = digit_of(drv_code, 1'b0);
         if (digit != 0)
         begin
            m_held[digit-1] = 1'b1;
            case (digit)
               1: m_wave    = dds_pkg::WAVE_SINE;
               2: m_wave    = dds_pkg::WAVE_COSINE;
               3: m_wave    = dds_pkg::WAVE_SQUARE;
               4: m_wave    = dds_pkg::WAVE_SAW;
               5: m_mod_sel = dds_pkg::MOD_ASK;
               6: m_mod_sel = dds_pkg::MOD_BPSK;
               7: m_mod_sel = dds_pkg::MOD_FSK;
               default: ;   // digit 8 only held
            endcase
         end
         digit = digit_of(drv_code, 1'b1);
         if (digit != 0)
            m_held[digit-1] = 1'b0;
      end
      m_sample_cnt = strobe ? 0 : m_sample_cnt + 1;
      m_bit_cnt    = bit_step ? 0 : m_bit_cnt + 1;
      if (bit_step)
         m_lfsr = {m_lfsr[3:0], m_lfsr[4] ^ m_lfsr[2]};
      m_phase = m_phase + tuning;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // stimulus and per-cycle compare
   ////////////////////////////////////////////////////////////////////////////

   task automatic drive_random_event();
      int digit;
      drv_ready = ($urandom_range(3) == 0);   // one cycle in four
      drv_code  = 8'($urandom);               // idle code must be ignored
      if (drv_ready)
      begin
         if ($urandom_range(9) == 0)
         begin
            while (digit_of(drv_code, 1'b0) != 0 || digit_of(drv_code, 1'b1) != 0)
               drv_code = 8'($urandom);
         end
         else
         begin
            digit    = $urandom_range(8, 1);
            drv_code = ($urandom_range(2) != 0) ? MAKE_CODES[digit-1] : BREAK_CODES[digit-1];
         end
      end
      key_event_ready <= drv_ready;
      key_event       <= drv_code;
   endtask

   task automatic compare_outputs();
      check_keys(held_keys, m_held);
      check_bit("data_bit", data_bit, m_lfsr[0]);
      check_bit("sample_valid", sample_valid, m_valid);
      check_sample("sig_sample", sig_sample, m_sig);
      check_sample("mod_sample", mod_sample, m_mod);
      since_valid++;
      if (sample_valid)
      begin
         if (valid_count > 0 && since_valid != SAMPLE_PERIOD)
         begin
            $display("mismatch at %0t ns: sample_valid after %0d cycles, expected %0d",
                     $time, since_valid, SAMPLE_PERIOD);
            stop_with_failure();
         end
         since_valid = 0;
         valid_count++;
         waves_seen[m_sampled_wave] = 1'b1;
      end
   endtask

   always @(posedge CLK_25MHZ)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count == TIMEOUT_CYCLES)
      begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         stop_with_failure();
      end
   end

   initial
   begin
      void'($urandom(5720));
      reset_from_key  = 1'b1;
      key_event_ready = 1'b0;
      key_event       = '0;
      drv_ready       = 1'b0;
      drv_code        = '0;
      waves_seen      = '0;
      since_valid     = 0;
      valid_count     = 0;
      reset_model();
      repeat (RESET_CYCLES) @(posedge CLK_25MHZ);
      reset_from_key <= 1'b0;
      @(negedge CLK_25MHZ);
      check_keys(held_keys, '0);              // state straight out of reset
      check_bit("data_bit", data_bit, 1'b1);
      check_bit("sample_valid", sample_valid, 1'b0);
      repeat (RUN_CYCLES)
      begin
         @(posedge CLK_25MHZ);
         step_model();
         drive_random_event();
         @(negedge CLK_25MHZ);
         compare_outputs();
      end
      if (waves_seen != 4'b1111)
      begin
         $display("not every waveform was sampled during the run (seen %b)", waves_seen);
         stop_with_failure();
      end
      else
      begin
         $display("Test passed");
         $finish;
      end
   end

endmodule

// ==== sources.f ====
dds_pkg.sv
lab_control.sv
lfsr_bit_source.sv
dds_waveform.sv
shift_keyer.sv
dds_lab_top.sv
tb_dds_lab.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_dds_lab
FILELIST  = sources.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^Test passed$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
